// File: Bender.yml
package:
  name: decode_issue

sources:
  - decode_issue_pkg.sv
  - instr_decoder.sv
  - issue_stage_reg.sv
  - unit_dispatch.sv
  - decode_issue_top.sv
  - target: test
    files:
      - tb_decode_issue.sv

// File: decode_issue_pkg.sv
package decode_issue_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_UNITS = 4;

    // Major opcode, instruction bits 6 to 2
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    // Bit positions in the unit vectors
    typedef enum logic [1:0] {
        UNIT_BRANCH = 2'd0,
        UNIT_ALU    = 2'd1,
        UNIT_LS     = 2'd2,
        UNIT_GC     = 2'd3
    } unit_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_XOR = 2'b01,
        ALU_OR  = 2'b10,
        ALU_AND = 2'b11
    } alu_logic_op_t;

    // Function 3 codes of the integer ops
    localparam logic [2:0] ADD_SUB_FN3 = 3'b000;
    localparam logic [2:0] SLT_FN3     = 3'b010;
    localparam logic [2:0] SLTU_FN3    = 3'b011;
    localparam logic [2:0] XOR_FN3     = 3'b100;
    localparam logic [2:0] OR_FN3      = 3'b110;
    localparam logic [2:0] AND_FN3     = 3'b111;

endpackage

// File: decode_issue_top.sv
`timescale 1ns/10ps

module decode_issue_top #(
    parameter int ID_WIDTH = 3
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    decode_valid,
    input  logic [decode_issue_pkg::XLEN-1:0]       instruction,
    input  logic [decode_issue_pkg::XLEN-1:0]       pc,
    input  logic [ID_WIDTH-1:0]                     id,
    input  logic                                    issue_hold,
    input  logic                                    flush,
    input  logic [decode_issue_pkg::NUM_UNITS-1:0]  unit_ready,
    input  logic [decode_issue_pkg::XLEN-1:0]       rs1_data,
    input  logic [decode_issue_pkg::XLEN-1:0]       rs2_data,
    input  logic                                    rs1_busy,
    input  logic                                    rs2_busy,
    output logic                                    decode_advance,
    output logic [decode_issue_pkg::NUM_UNITS-1:0]  unit_issue,
    output logic [ID_WIDTH-1:0]                     issue_id,
    output logic [decode_issue_pkg::XLEN-1:0]       issue_pc,
    output logic [decode_issue_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [decode_issue_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [decode_issue_pkg::XLEN-1:0]       alu_in1,
    output logic [decode_issue_pkg::XLEN-1:0]       alu_in2,
    output decode_issue_pkg::alu_logic_op_t         alu_logic_op,
    output logic                                    alu_subtract,
    output logic [11:0]                             ls_offset,
    output logic                                    ls_load,
    output logic                                    ls_store,
    output logic [20:0]                             branch_offset,
    output logic                                    branch_jal,
    output logic                                    branch_jalr
);

    // Decoder outputs
    logic [decode_issue_pkg::NUM_UNITS-1:0]  dec_unit_needed;
    logic                                    dec_uses_rs1;
    logic                                    dec_uses_rs2;
    logic [decode_issue_pkg::REG_ADDR_W-1:0] dec_rs1_addr;
    logic [decode_issue_pkg::REG_ADDR_W-1:0] dec_rs2_addr;
    logic                                    dec_alu_rs1_sel_pc;
    logic                                    dec_alu_rs1_zero;
    logic                                    dec_alu_rs2_use_reg;
    logic [decode_issue_pkg::XLEN-1:0]       dec_alu_imm;
    decode_issue_pkg::alu_logic_op_t         dec_alu_logic_op;
    logic                                    dec_alu_subtract;
    logic [11:0]                             dec_ls_offset;
    logic                                    dec_is_load;
    logic                                    dec_is_store;
    logic [20:0]                             dec_branch_offset;
    logic                                    dec_is_jal;
    logic                                    dec_is_jalr;

    // Issue stage state
    logic                                    stage_valid;
    logic                                    instruction_issued;
    logic [decode_issue_pkg::NUM_UNITS-1:0]  issue_unit_needed;
    logic                                    issue_uses_rs1;
    logic                                    issue_uses_rs2;
    logic                                    issue_alu_rs1_sel_pc;
    logic                                    issue_alu_rs1_zero;
    logic                                    issue_alu_rs2_use_reg;
    logic [decode_issue_pkg::XLEN-1:0]       issue_alu_imm;

    instr_decoder decoder (
        .instruction     (instruction),
        .unit_needed     (dec_unit_needed),
        .uses_rs1        (dec_uses_rs1),
        .uses_rs2        (dec_uses_rs2),
        .rs1_addr        (dec_rs1_addr),
        .rs2_addr        (dec_rs2_addr),
        .alu_rs1_sel_pc  (dec_alu_rs1_sel_pc),
        .alu_rs1_zero    (dec_alu_rs1_zero),
        .alu_rs2_use_reg (dec_alu_rs2_use_reg),
        .alu_imm         (dec_alu_imm),
        .alu_logic_op    (dec_alu_logic_op),
        .alu_subtract    (dec_alu_subtract),
        .ls_offset       (dec_ls_offset),
        .is_load         (dec_is_load),
        .is_store        (dec_is_store),
        .branch_offset   (dec_branch_offset),
        .is_jal          (dec_is_jal),
        .is_jalr         (dec_is_jalr)
    );

    issue_stage_reg #(
        .ID_WIDTH (ID_WIDTH)
    ) issue_reg (
        .clk                   (clk),
        .rst                   (rst),
        .decode_valid          (decode_valid),
        .issue_hold            (issue_hold),
        .flush                 (flush),
        .instruction_issued    (instruction_issued),
        .pc                    (pc),
        .id                    (id),
        .unit_needed           (dec_unit_needed),
        .uses_rs1              (dec_uses_rs1),
        .uses_rs2              (dec_uses_rs2),
        .rs1_addr              (dec_rs1_addr),
        .rs2_addr              (dec_rs2_addr),
        .alu_rs1_sel_pc        (dec_alu_rs1_sel_pc),
        .alu_rs1_zero          (dec_alu_rs1_zero),
        .alu_rs2_use_reg       (dec_alu_rs2_use_reg),
        .alu_imm               (dec_alu_imm),
        .alu_logic_op          (dec_alu_logic_op),
        .alu_subtract          (dec_alu_subtract),
        .ls_offset             (dec_ls_offset),
        .is_load               (dec_is_load),
        .is_store              (dec_is_store),
        .branch_offset         (dec_branch_offset),
        .is_jal                (dec_is_jal),
        .is_jalr               (dec_is_jalr),
        .decode_advance        (decode_advance),
        .stage_valid           (stage_valid),
        .issue_pc              (issue_pc),
        .issue_id              (issue_id),
        .issue_unit_needed     (issue_unit_needed),
        .issue_uses_rs1        (issue_uses_rs1),
        .issue_uses_rs2        (issue_uses_rs2),
        .issue_rs1_addr        (rs1_addr),
        .issue_rs2_addr        (rs2_addr),
        .issue_alu_rs1_sel_pc  (issue_alu_rs1_sel_pc),
        .issue_alu_rs1_zero    (issue_alu_rs1_zero),
        .issue_alu_rs2_use_reg (issue_alu_rs2_use_reg),
        .issue_alu_imm         (issue_alu_imm),
        .issue_alu_logic_op    (alu_logic_op),
        .issue_alu_subtract    (alu_subtract),
        .issue_ls_offset       (ls_offset),
        .issue_is_load         (ls_load),
        .issue_is_store        (ls_store),
        .issue_branch_offset   (branch_offset),
        .issue_is_jal          (branch_jal),
        .issue_is_jalr         (branch_jalr)
    );

    unit_dispatch dispatch (
        .stage_valid        (stage_valid),
        .issue_hold         (issue_hold),
        .flush              (flush),
        .unit_needed        (issue_unit_needed),
        .unit_ready         (unit_ready),
        .uses_rs1           (issue_uses_rs1),
        .uses_rs2           (issue_uses_rs2),
        .rs1_busy           (rs1_busy),
        .rs2_busy           (rs2_busy),
        .rs1_data           (rs1_data),
        .rs2_data           (rs2_data),
        .issue_pc           (issue_pc),
        .alu_rs1_sel_pc     (issue_alu_rs1_sel_pc),
        .alu_rs1_zero       (issue_alu_rs1_zero),
        .alu_rs2_use_reg    (issue_alu_rs2_use_reg),
        .alu_imm            (issue_alu_imm),
        .instruction_issued (instruction_issued),
        .unit_issue         (unit_issue),
        .alu_in1            (alu_in1),
        .alu_in2            (alu_in2)
    );

endmodule

// File: instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  logic [decode_issue_pkg::XLEN-1:0]       instruction,
    output logic [decode_issue_pkg::NUM_UNITS-1:0]  unit_needed,
    output logic                                    uses_rs1,
    output logic                                    uses_rs2,
    output logic [decode_issue_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [decode_issue_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic                                    alu_rs1_sel_pc,
    output logic                                    alu_rs1_zero,
    output logic                                    alu_rs2_use_reg,
    output logic [decode_issue_pkg::XLEN-1:0]       alu_imm,
    output decode_issue_pkg::alu_logic_op_t         alu_logic_op,
    output logic                                    alu_subtract,
    output logic [11:0]                             ls_offset,
    output logic                                    is_load,
    output logic                                    is_store,
    output logic [20:0]                             branch_offset,
    output logic                                    is_jal,
    output logic                                    is_jalr
);

    decode_issue_pkg::opcode_t opcode;
    logic [2:0] fn3;
    logic is_arith_op;

    assign opcode = decode_issue_pkg::opcode_t'(instruction[6:2]);
    assign fn3 = instruction[14:12];
    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];

    // Register and immediate integer ops, the only ones that look at fn3
    assign is_arith_op = opcode inside {decode_issue_pkg::ARITH, decode_issue_pkg::ARITH_IMM};

    ////////////////////////////////////////
    // Unit selection
    assign unit_needed[decode_issue_pkg::UNIT_BRANCH] = opcode inside
        {decode_issue_pkg::BRANCH, decode_issue_pkg::JAL, decode_issue_pkg::JALR};
    assign unit_needed[decode_issue_pkg::UNIT_ALU] = is_arith_op || opcode inside
        {decode_issue_pkg::AUIPC, decode_issue_pkg::LUI,
         decode_issue_pkg::JAL, decode_issue_pkg::JALR};
    assign unit_needed[decode_issue_pkg::UNIT_LS] = opcode inside
        {decode_issue_pkg::LOAD, decode_issue_pkg::STORE};
    assign unit_needed[decode_issue_pkg::UNIT_GC] = opcode inside
        {decode_issue_pkg::SYSTEM, decode_issue_pkg::FENCE};

    // Source register use
    assign uses_rs1 = !(opcode inside {decode_issue_pkg::LUI, decode_issue_pkg::AUIPC,
                                       decode_issue_pkg::JAL, decode_issue_pkg::FENCE});
    assign uses_rs2 = opcode inside {decode_issue_pkg::BRANCH, decode_issue_pkg::STORE,
                                     decode_issue_pkg::ARITH};

    ////////////////////////////////////////
    // ALU operands
    assign alu_rs1_sel_pc = opcode inside {decode_issue_pkg::AUIPC, decode_issue_pkg::JAL,
                                           decode_issue_pkg::JALR};
    assign alu_rs1_zero = (opcode == decode_issue_pkg::LUI);
    assign alu_rs2_use_reg = !(opcode inside {decode_issue_pkg::LUI, decode_issue_pkg::AUIPC,
                                              decode_issue_pkg::JAL, decode_issue_pkg::JALR,
                                              decode_issue_pkg::ARITH_IMM});

    always_comb begin
        if (opcode inside {decode_issue_pkg::LUI, decode_issue_pkg::AUIPC})
            alu_imm = {instruction[31:12], 12'b0};
        else if (opcode inside {decode_issue_pkg::JAL, decode_issue_pkg::JALR})
            alu_imm = 32'd4;  // link address is pc + 4
        else
            alu_imm = {{20{instruction[31]}}, instruction[31:20]};
    end

    // SUB only exists in the register form
    assign alu_subtract = is_arith_op &&
        ((fn3 inside {decode_issue_pkg::SLT_FN3, decode_issue_pkg::SLTU_FN3}) ||
         (opcode == decode_issue_pkg::ARITH && fn3 == decode_issue_pkg::ADD_SUB_FN3 &&
          instruction[30]));

    always_comb begin
        case (fn3)
            decode_issue_pkg::XOR_FN3: alu_logic_op = decode_issue_pkg::ALU_XOR;
            decode_issue_pkg::OR_FN3:  alu_logic_op = decode_issue_pkg::ALU_OR;
            decode_issue_pkg::AND_FN3: alu_logic_op = decode_issue_pkg::ALU_AND;
            default:                   alu_logic_op = decode_issue_pkg::ALU_ADD;
        endcase
        // Jumps and upper immediates go through the adder
        if (!is_arith_op)
            alu_logic_op = decode_issue_pkg::ALU_ADD;
    end

    ////////////////////////////////////////
    // Load-store and branch offsets
    assign is_load = (opcode == decode_issue_pkg::LOAD);
    assign is_store = (opcode == decode_issue_pkg::STORE);
    assign ls_offset = is_store ? {instruction[31:25], instruction[11:7]} : instruction[31:20];

    assign is_jal = (opcode == decode_issue_pkg::JAL);
    assign is_jalr = (opcode == decode_issue_pkg::JALR);

    always_comb begin
        if (is_jal)
            branch_offset = {instruction[31], instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
        else if (is_jalr)
            branch_offset = {{9{instruction[31]}}, instruction[31:20]};
        else
            branch_offset = {{8{instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
    end

endmodule

// File: issue_stage_reg.sv
`timescale 1ns/10ps

module issue_stage_reg #(
    parameter int ID_WIDTH = 3
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    decode_valid,
    input  logic                                    issue_hold,
    input  logic                                    flush,
    input  logic                                    instruction_issued,
    input  logic [decode_issue_pkg::XLEN-1:0]       pc,
    input  logic [ID_WIDTH-1:0]                     id,
    input  logic [decode_issue_pkg::NUM_UNITS-1:0]  unit_needed,
    input  logic                                    uses_rs1,
    input  logic                                    uses_rs2,
    input  logic [decode_issue_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [decode_issue_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic                                    alu_rs1_sel_pc,
    input  logic                                    alu_rs1_zero,
    input  logic                                    alu_rs2_use_reg,
    input  logic [decode_issue_pkg::XLEN-1:0]       alu_imm,
    input  decode_issue_pkg::alu_logic_op_t         alu_logic_op,
    input  logic                                    alu_subtract,
    input  logic [11:0]                             ls_offset,
    input  logic                                    is_load,
    input  logic                                    is_store,
    input  logic [20:0]                             branch_offset,
    input  logic                                    is_jal,
    input  logic                                    is_jalr,
    output logic                                    decode_advance,
    output logic                                    stage_valid,
    output logic [decode_issue_pkg::XLEN-1:0]       issue_pc,
    output logic [ID_WIDTH-1:0]                     issue_id,
    output logic [decode_issue_pkg::NUM_UNITS-1:0]  issue_unit_needed,
    output logic                                    issue_uses_rs1,
    output logic                                    issue_uses_rs2,
    output logic [decode_issue_pkg::REG_ADDR_W-1:0] issue_rs1_addr,
    output logic [decode_issue_pkg::REG_ADDR_W-1:0] issue_rs2_addr,
    output logic                                    issue_alu_rs1_sel_pc,
    output logic                                    issue_alu_rs1_zero,
    output logic                                    issue_alu_rs2_use_reg,
    output logic [decode_issue_pkg::XLEN-1:0]       issue_alu_imm,
    output decode_issue_pkg::alu_logic_op_t         issue_alu_logic_op,
    output logic                                    issue_alu_subtract,
    output logic [11:0]                             issue_ls_offset,
    output logic                                    issue_is_load,
    output logic                                    issue_is_store,
    output logic [20:0]                             issue_branch_offset,
    output logic                                    issue_is_jal,
    output logic                                    issue_is_jalr
);

    logic load_fields;

    // Stage can take a new instruction when empty or when the held one leaves
    assign decode_advance = decode_valid & ~issue_hold & (~stage_valid | instruction_issued);
    assign load_fields = decode_advance | (~stage_valid & ~decode_valid);

    always_ff @(posedge clk) begin
        if (rst | flush)
            stage_valid <= 1'b0;
        else if (decode_advance)
            stage_valid <= 1'b1;
        else if (instruction_issued)
            stage_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load_fields) begin
            issue_pc <= pc;
            issue_id <= id;
            issue_unit_needed <= unit_needed;
            issue_uses_rs1 <= uses_rs1;
            issue_uses_rs2 <= uses_rs2;
            issue_rs1_addr <= rs1_addr;
            issue_rs2_addr <= rs2_addr;
            issue_alu_rs1_sel_pc <= alu_rs1_sel_pc;
            issue_alu_rs1_zero <= alu_rs1_zero;
            issue_alu_rs2_use_reg <= alu_rs2_use_reg;
            issue_alu_imm <= alu_imm;
            issue_alu_logic_op <= alu_logic_op;
            issue_alu_subtract <= alu_subtract;
            issue_ls_offset <= ls_offset;
            issue_is_load <= is_load;
            issue_is_store <= is_store;
            issue_branch_offset <= branch_offset;
            issue_is_jal <= is_jal;
            issue_is_jalr <= is_jalr;
        end
    end

endmodule

// File: tb_decode_issue.sv
`timescale 1ns/10ps

module tb_decode_issue;

    localparam int NUM_INSTR = 150;
    // About a dozen cycles per instruction of headroom, plus reset and drain
    localparam int MAX_CYCLES = NUM_INSTR * 12 + 200;

    typedef struct packed {
        logic [2:0]  id;
        logic [31:0] pc;
        logic [3:0]  units;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        use1;
        logic        use2;
        logic [1:0]  in1_kind;
        logic        in2_reg;
        logic [31:0] imm;
        logic        sub;
        logic [1:0]  logic_op;
        logic [11:0] ls_off;
        logic        ld;
        logic        st;
        logic [20:0] br_off;
        logic        jal;
        logic        jalr;
    } exp_t;

    logic clk;
    logic rst;
    logic decode_valid;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic [2:0] id;
    logic issue_hold;
    logic flush;
    logic [3:0] unit_ready;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic rs1_busy;
    logic rs2_busy;
    logic decode_advance;
    logic [3:0] unit_issue;
    logic [2:0] issue_id;
    logic [31:0] issue_pc;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [31:0] alu_in1;
    logic [31:0] alu_in2;
    decode_issue_pkg::alu_logic_op_t alu_logic_op;
    logic alu_subtract;
    logic [11:0] ls_offset;
    logic ls_load;
    logic ls_store;
    logic [20:0] branch_offset;
    logic branch_jal;
    logic branch_jalr;

    integer seed = 32'h870b_d59b;
    int cycles = 0;
    int mismatches = 0;
    int failures = 0;
    int issued_count = 0;
    exp_t cur;
    exp_t model[$];

    decode_issue_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        mismatches++;
    endtask

    task automatic finish_run;
        $display("Errors: %0d mismatches, %0d other failures, %0d instructions issued",
                 mismatches, failures, issued_count);
        if (mismatches == 0 && failures == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    ////////////////////////////////////////
    // Stimulus helpers

    task automatic randomize_env(input logic allow_flush);
        // Each unit ready about three cycles in four
        unit_ready = $random(seed) | $random(seed);
        rs1_busy = (($random(seed) & 3) == 0);
        rs2_busy = (($random(seed) & 3) == 0);
        issue_hold = (($random(seed) & 7) == 0);
        flush = allow_flush && (($random(seed) & 3) == 0);
        rs1_data = $random(seed);
        rs2_data = $random(seed);
    endtask

    // Logic op the ALU runs for an integer fn3
    function automatic logic [1:0] alu_op_for_fn3(input logic [2:0] f);
        case (f)
            3'b100:  return decode_issue_pkg::ALU_XOR;
            3'b110:  return decode_issue_pkg::ALU_OR;
            3'b111:  return decode_issue_pkg::ALU_AND;
            default: return decode_issue_pkg::ALU_ADD;
        endcase
    endfunction

    // Random RV32I word plus what the issue stage should make of it
    task automatic encode_instr(input int n);
        logic [31:0] r;
        logic [4:0] rd;
        logic [2:0] fn3;
        logic [12:0] b;
        logic [20:0] j;
        int k;
        r = $random(seed);
        rd = $random(seed);
        fn3 = $random(seed);
        k = {$random(seed)} % 11;
        b = {r[31:20], 1'b0};
        j = {r[31:12], 1'b0};
        cur = '0;
        cur.id = n[2:0];
        cur.pc = 32'h0000_1000 + 4 * n;
        cur.imm = {{20{r[31]}}, r[31:20]};
        case (k)
            0: begin
                instruction = {r[31:20], r[19:15], fn3, rd, 7'b0000011};
                cur.units = 4'b0100;
                cur.use1 = 1'b1;
                cur.ls_off = r[31:20];
                cur.ld = 1'b1;
            end
            1: begin
                instruction = {r[31:25], r[24:20], r[19:15], fn3, r[11:7], 7'b0100011};
                cur.units = 4'b0100;
                {cur.use1, cur.use2} = 2'b11;
                cur.ls_off = {r[31:25], r[11:7]};
                cur.st = 1'b1;
            end
            2: begin
                instruction = {b[12], b[10:5], r[24:20], r[19:15], fn3, b[4:1], b[11],
                               7'b1100011};
                cur.units = 4'b0001;
                {cur.use1, cur.use2} = 2'b11;
                cur.br_off = {{8{b[12]}}, b};
            end
            3: begin
                instruction = {r[31:20], r[19:15], 3'b000, rd, 7'b1100111};
                cur.units = 4'b0011;
                cur.use1 = 1'b1;
                cur.in1_kind = 2'd1;
                cur.imm = 32'd4;
                cur.br_off = {{9{r[31]}}, r[31:20]};
                cur.jalr = 1'b1;
            end
            4: begin
                instruction = {j[20], j[10:1], j[11], j[19:12], rd, 7'b1101111};
                cur.units = 4'b0011;
                cur.in1_kind = 2'd1;
                cur.imm = 32'd4;
                cur.br_off = j;
                cur.jal = 1'b1;
            end
            5: begin
                instruction = {r[31:20], r[19:15], fn3, rd, 7'b0010011};
                cur.units = 4'b0010;
                cur.use1 = 1'b1;
                cur.sub = (fn3 == 3'b010 || fn3 == 3'b011);
                cur.logic_op = alu_op_for_fn3(fn3);
            end
            6: begin
                instruction = {1'b0, r[30], 5'b0, r[24:20], r[19:15], fn3, rd, 7'b0110011};
                cur.units = 4'b0010;
                {cur.use1, cur.use2} = 2'b11;
                cur.in2_reg = 1'b1;
                cur.sub = (fn3 == 3'b010 || fn3 == 3'b011 || (fn3 == 3'b000 && r[30]));
                cur.logic_op = alu_op_for_fn3(fn3);
            end
            7, 8: begin
                instruction = {r[31:12], rd, (k == 7) ? 7'b0010111 : 7'b0110111};
                cur.units = 4'b0010;
                cur.in1_kind = (k == 7) ? 2'd1 : 2'd2;
                cur.imm = {r[31:12], 12'b0};
            end
            9: begin
                instruction = {r[31:20], r[19:15], fn3, rd, 7'b0001111};
                cur.units = 4'b1000;
            end
            default: begin
                instruction = {r[31:20], r[19:15], fn3, rd, 7'b1110011};
                cur.units = 4'b1000;
                cur.use1 = 1'b1;
            end
        endcase
        cur.rs1 = instruction[19:15];
        cur.rs2 = instruction[24:20];
        pc = cur.pc;
        id = cur.id;
    endtask

    ////////////////////////////////////////
    // Checks against the expected queue

    always @(negedge clk) begin : check_outputs
        exp_t head;
        logic valid;
        logic ops_free;
        logic go;
        logic [31:0] exp_in1;
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped: cycle limit of %0d reached before all instructions issued",
                     MAX_CYCLES);
            failures++;
            finish_run();
        end else if (rst) begin
            model.delete();
        end else begin
            valid = (model.size() != 0);
            head = valid ? model[0] : '0;
            // Load-store looks only at rs1
            ops_free = !(head.use1 && rs1_busy) &&
                       (head.units[2] || !(head.use2 && rs2_busy));
            go = valid && !issue_hold && !flush && ((head.units & ~unit_ready) == 4'b0) &&
                 ops_free;
            assert (unit_issue == (go ? head.units : 4'b0))
                else report_mismatch("unit_issue", unit_issue, go ? head.units : 4'b0);
            assert (decode_advance == (decode_valid && !issue_hold && (!valid || go)))
                else report_mismatch("decode_advance", decode_advance,
                                     decode_valid && !issue_hold && (!valid || go));
            if (valid) begin
                assert (rs1_addr == head.rs1) else report_mismatch("rs1_addr", rs1_addr, head.rs1);
                assert (rs2_addr == head.rs2) else report_mismatch("rs2_addr", rs2_addr, head.rs2);
            end
            if (go) begin
                exp_in1 = (head.in1_kind == 2'd0) ? rs1_data :
                          (head.in1_kind == 2'd1) ? head.pc : 32'd0;
                assert (issue_id == head.id) else report_mismatch("issue_id", issue_id, head.id);
                assert (issue_pc == head.pc) else report_mismatch("issue_pc", issue_pc, head.pc);
                if (head.units[1]) begin
                    assert (alu_in1 == exp_in1) else report_mismatch("alu_in1", alu_in1, exp_in1);
                    assert (alu_in2 == (head.in2_reg ? rs2_data : head.imm))
                        else report_mismatch("alu_in2", alu_in2,
                                             head.in2_reg ? rs2_data : head.imm);
                    assert (alu_subtract == head.sub)
                        else report_mismatch("alu_subtract", alu_subtract, head.sub);
                    assert (alu_logic_op == head.logic_op)
                        else report_mismatch("alu_logic_op", alu_logic_op, head.logic_op);
                end
                if (head.units[2]) begin
                    assert ({ls_offset, ls_load, ls_store} == {head.ls_off, head.ld, head.st})
                        else report_mismatch("ls_offset/load/store",
                                             {ls_offset, ls_load, ls_store},
                                             {head.ls_off, head.ld, head.st});
                end
                if (head.units[0]) begin
                    assert ({branch_offset, branch_jal, branch_jalr} ==
                            {head.br_off, head.jal, head.jalr})
                        else report_mismatch("branch_offset/jal/jalr",
                                             {branch_offset, branch_jal, branch_jalr},
                                             {head.br_off, head.jal, head.jalr});
                end
                void'(model.pop_front());
                issued_count++;
            end
            // A flush drops the held instruction and anything taken alongside it
            if (flush)
                model.delete();
            else if (decode_valid && decode_advance)
                model.push_back(cur);
        end
    end

    ////////////////////////////////////////
    // Main sequence

    initial begin : stimulus
        logic taken;
        rst = 1'b1;
        decode_valid = 1'b0;
        instruction = '0;
        pc = '0;
        id = '0;
        issue_hold = 1'b0;
        flush = 1'b0;
        unit_ready = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_busy = 1'b0;
        rs2_busy = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            encode_instr(n);
            decode_valid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                randomize_env(1'b0);
                @(negedge clk);
                taken = decode_advance;
                @(posedge clk);
                #10;
            end
            // Occasional bubble, the only place a flush is raised
            if (($random(seed) & 3) == 0) begin
                decode_valid = 1'b0;
                randomize_env(1'b1);
                @(posedge clk);
                #10;
            end
        end
        decode_valid = 1'b0;
        issue_hold = 1'b0;
        flush = 1'b0;
        unit_ready = 4'hf;
        {rs1_busy, rs2_busy} = 2'b00;
        while (model.size() != 0) begin
            @(posedge clk);
            #10;
        end
        repeat (2) @(posedge clk);
        finish_run();
    end

endmodule

// File: unit_dispatch.sv
`timescale 1ns/10ps

module unit_dispatch (
    input  logic                                   stage_valid,
    input  logic                                   issue_hold,
    input  logic                                   flush,
    input  logic [decode_issue_pkg::NUM_UNITS-1:0] unit_needed,
    input  logic [decode_issue_pkg::NUM_UNITS-1:0] unit_ready,
    input  logic                                   uses_rs1,
    input  logic                                   uses_rs2,
    input  logic                                   rs1_busy,
    input  logic                                   rs2_busy,
    input  logic [decode_issue_pkg::XLEN-1:0]      rs1_data,
    input  logic [decode_issue_pkg::XLEN-1:0]      rs2_data,
    input  logic [decode_issue_pkg::XLEN-1:0]      issue_pc,
    input  logic                                   alu_rs1_sel_pc,
    input  logic                                   alu_rs1_zero,
    input  logic                                   alu_rs2_use_reg,
    input  logic [decode_issue_pkg::XLEN-1:0]      alu_imm,
    output logic                                   instruction_issued,
    output logic [decode_issue_pkg::NUM_UNITS-1:0] unit_issue,
    output logic [decode_issue_pkg::XLEN-1:0]      alu_in1,
    output logic [decode_issue_pkg::XLEN-1:0]      alu_in2
);

    logic issue_valid;
    logic rs1_conflict;
    logic rs2_conflict;
    logic [decode_issue_pkg::NUM_UNITS-1:0] unit_operands_ready;
    logic units_ready;
    logic operands_ready;

    ////////////////////////////////////////
    // Issue decision
    assign issue_valid = stage_valid & ~issue_hold & ~flush;

    assign rs1_conflict = uses_rs1 & rs1_busy;
    assign rs2_conflict = uses_rs2 & rs2_busy;

    // Load-store forwards store data itself, so only its address register matters
    always_comb begin
        unit_operands_ready = {decode_issue_pkg::NUM_UNITS{~rs1_conflict & ~rs2_conflict}};
        unit_operands_ready[decode_issue_pkg::UNIT_LS] = ~rs1_conflict;
    end

    // Every needed unit must be ready, jumps need two at once
    assign units_ready = (|unit_needed) && ((unit_needed & ~unit_ready) == '0);
    assign operands_ready = ((unit_needed & ~unit_operands_ready) == '0);

    assign instruction_issued = issue_valid & units_ready & operands_ready;
    assign unit_issue = instruction_issued ? unit_needed : '0;

    ////////////////////////////////////////
    // ALU operand muxes
    always_comb begin
        if (alu_rs1_sel_pc)
            alu_in1 = issue_pc;
        else if (alu_rs1_zero)
            alu_in1 = '0;
        else
            alu_in1 = rs1_data;
    end

    assign alu_in2 = alu_rs2_use_reg ? rs2_data : alu_imm;

endmodule

// File: verilog.f
decode_issue_pkg.sv
instr_decoder.sv
issue_stage_reg.sv
unit_dispatch.sv
decode_issue_top.sv
tb_decode_issue.sv
